/* hdl/vend_consts.svh */
`ifndef VEND_CONSTS_SVH
`define VEND_CONSTS_SVH

`define VEND_AMT_W          7     // Covers credit up to 120 cents.

`define VEND_COIN_NICKEL    5
`define VEND_COIN_DIME      10
`define VEND_COIN_QUARTER   25

`define VEND_PRICE_MIN      5
`define VEND_PRICE_MAX      95
`define VEND_PRICE_DEFAULT  30

`define VEND_ADDR_PRICE     8'h00
`define VEND_ADDR_SALES     8'h04
`define VEND_ADDR_REJECTS   8'h08
`define VEND_ADDR_STATUS    8'h0c

`endif

/* hdl/vend_pkg.sv */
`default_nettype none

`include "vend_consts.svh"

package vend_pkg;

    typedef logic [`VEND_AMT_W-1:0] amount_t;   // Cents.
    typedef logic [15:0]            count_t;

    typedef struct packed {
        logic nickel;
        logic dime;
        logic quarter;
    } coin_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {IDLE, COLLECT, VEND, PAYOUT} vend_state_e;

endpackage

`default_nettype wire

/* hdl/coin_acceptor.sv */
`timescale 1ns/100ps
`default_nettype none

module coin_acceptor (
    input  wire                clk,
    input  wire                rst_n,
    input  wire vend_pkg::coin_t coin_pins,
    input  wire                accept_en,
    output vend_pkg::coin_t    coin_evt,
    output logic               coin_valid,
    output logic               reject
);

    vend_pkg::coin_t sync1_q, sync2_q, prev_q;
    vend_pkg::coin_t pend_q, evt_q;
    vend_pkg::coin_t rise, avail, pick;

    assign rise  = sync2_q & ~prev_q;
    assign avail = pend_q | rise;

    // Highest value first, one coin per cycle.
    always_comb begin
        pick = '0;
        if (avail.quarter)
            pick.quarter = 1'b1;
        else if (avail.dime)
            pick.dime = 1'b1;
        else if (avail.nickel)
            pick.nickel = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
            pend_q  <= '0;
            evt_q   <= '0;
        end else begin
            sync1_q <= coin_pins;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            pend_q  <= avail & ~pick;           // Others wait their turn.
            evt_q   <= pick;
        end
    end

    assign coin_evt   = evt_q;
    assign coin_valid = (evt_q != '0) && accept_en;
    assign reject     = (evt_q != '0) && !accept_en;

endmodule

`default_nettype wire

/* hdl/vend_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vend_consts.svh"

module vend_fsm (
    input  wire                clk,
    input  wire                rst_n,
    input  wire vend_pkg::coin_t coin_evt,
    input  wire                coin_valid,
    input  wire                coin_return,
    input  wire vend_pkg::amount_t price,
    output logic               accept_en,
    output logic               dispense,
    output vend_pkg::amount_t  credit,
    output logic               pay_start,
    output vend_pkg::amount_t  pay_amount,
    input  wire                pay_busy,
    output logic               busy
);

    vend_pkg::vend_state_e state_q, state_d;
    vend_pkg::amount_t     credit_q, credit_d;
    vend_pkg::amount_t     price_q;
    vend_pkg::amount_t     coin_val;
    vend_pkg::amount_t     sum;
    logic                  latch_price;

    always_comb begin
        coin_val = '0;
        if (coin_evt.quarter)
            coin_val = vend_pkg::amount_t'(`VEND_COIN_QUARTER);
        else if (coin_evt.dime)
            coin_val = vend_pkg::amount_t'(`VEND_COIN_DIME);
        else if (coin_evt.nickel)
            coin_val = vend_pkg::amount_t'(`VEND_COIN_NICKEL);
    end

    assign sum = credit_q + coin_val;

    // **********************************************************************
    // Next state and outputs
    // **********************************************************************
    always_comb begin
        state_d     = state_q;
        credit_d    = credit_q;
        latch_price = 1'b0;
        dispense    = 1'b0;
        pay_start   = 1'b0;
        pay_amount  = '0;
        case (state_q)
            vend_pkg::IDLE: begin
                if (coin_valid) begin
                    credit_d    = coin_val;
                    latch_price = 1'b1;             // New price applies here.
                    state_d     = (coin_val >= price) ? vend_pkg::VEND : vend_pkg::COLLECT;
                end
            end
            vend_pkg::COLLECT: begin
                if (coin_return) begin
                    pay_start  = 1'b1;              // Full refund.
                    pay_amount = credit_q;
                    state_d    = vend_pkg::PAYOUT;
                end else if (coin_valid) begin
                    credit_d = sum;
                    if (sum >= price_q)
                        state_d = vend_pkg::VEND;
                end
            end
            vend_pkg::VEND: begin
                dispense = 1'b1;
                if (credit_q != price_q) begin
                    pay_start  = 1'b1;
                    pay_amount = credit_q - price_q;
                    state_d    = vend_pkg::PAYOUT;
                end else begin
                    credit_d = '0;
                    state_d  = vend_pkg::IDLE;
                end
            end
            vend_pkg::PAYOUT: begin
                if (!pay_busy) begin
                    credit_d = '0;
                    state_d  = vend_pkg::IDLE;
                end
            end
            default: state_d = vend_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= vend_pkg::IDLE;
            credit_q <= '0;
        end else begin
            state_q  <= state_d;
            credit_q <= credit_d;
        end
    end

    always_ff @(posedge clk) begin
        if (latch_price)
            price_q <= price;
    end

    // A coin racing a return request is rejected, not lost.
    assign accept_en = (state_q == vend_pkg::IDLE) ||
                       (state_q == vend_pkg::COLLECT && !coin_return);
    assign credit    = credit_q;
    assign busy      = (state_q != vend_pkg::IDLE);

endmodule

`default_nettype wire

/* hdl/change_maker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vend_consts.svh"

module change_maker (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                pay_start,
    input  wire vend_pkg::amount_t pay_amount,
    output logic               pay_busy,
    output vend_pkg::coin_t    coin_out
);

    vend_pkg::amount_t remain_q;
    vend_pkg::amount_t coin_val;

    // Largest coin that still fits.
    always_comb begin
        coin_out = '0;
        coin_val = '0;
        if (remain_q >= vend_pkg::amount_t'(`VEND_COIN_QUARTER)) begin
            coin_out.quarter = 1'b1;
            coin_val         = vend_pkg::amount_t'(`VEND_COIN_QUARTER);
        end else if (remain_q >= vend_pkg::amount_t'(`VEND_COIN_DIME)) begin
            coin_out.dime = 1'b1;
            coin_val      = vend_pkg::amount_t'(`VEND_COIN_DIME);
        end else if (remain_q >= vend_pkg::amount_t'(`VEND_COIN_NICKEL)) begin
            coin_out.nickel = 1'b1;
            coin_val        = vend_pkg::amount_t'(`VEND_COIN_NICKEL);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain_q <= '0;
        end else if (pay_start) begin
            remain_q <= pay_amount;
        end else if (remain_q != '0) begin
            remain_q <= remain_q - coin_val;    // Always a multiple of 5.
        end
    end

    assign pay_busy = (remain_q != '0);

endmodule

`default_nettype wire

/* hdl/vend_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vend_consts.svh"

module vend_regs (
    input  wire                clk,
    input  wire                rst_n,
    input  wire vend_pkg::apb_req_t apb,
    output vend_pkg::apb_rsp_t apb_rsp,
    output vend_pkg::amount_t  price,
    input  wire                dispense,
    input  wire                reject,
    input  wire vend_pkg::amount_t credit,
    input  wire                busy
);

    vend_pkg::amount_t price_q;
    vend_pkg::count_t  sales_q;
    vend_pkg::count_t  rejects_q;

    logic wr_en;
    logic rd_en;
    logic price_ok;
    logic wr_err;

    assign wr_en = apb.psel && apb.penable && apb.pwrite;
    assign rd_en = apb.psel && apb.penable && !apb.pwrite;

    // Range and nickel granularity.
    assign price_ok = (apb.pwdata >= 32'(`VEND_PRICE_MIN)) &&
                      (apb.pwdata <= 32'(`VEND_PRICE_MAX)) &&
                      ((apb.pwdata[`VEND_AMT_W-1:0] % vend_pkg::amount_t'(`VEND_COIN_NICKEL))
                       == '0);

    always_comb begin
        wr_err = 1'b1;
        case (apb.paddr)
            `VEND_ADDR_PRICE:   wr_err = !price_ok;
            `VEND_ADDR_REJECTS: wr_err = 1'b0;
            default:            wr_err = 1'b1;  // SALES, STATUS, unmapped.
        endcase
    end

    // **********************************************************************
    // Register updates
    // **********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            price_q   <= vend_pkg::amount_t'(`VEND_PRICE_DEFAULT);
            sales_q   <= '0;
            rejects_q <= '0;
        end else begin
            if (wr_en && apb.paddr == `VEND_ADDR_PRICE && price_ok)
                price_q <= apb.pwdata[`VEND_AMT_W-1:0];
            if (dispense && sales_q != '1)
                sales_q <= sales_q + 1'b1;          // Saturates.
            if (wr_en && apb.paddr == `VEND_ADDR_REJECTS)
                rejects_q <= '0;                    // Clear wins over a count.
            else if (reject && rejects_q != '1)
                rejects_q <= rejects_q + 1'b1;
        end
    end

    assign price = price_q;

    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;                     // No wait states.
        apb_rsp.pslverr = wr_en && wr_err;
        if (rd_en) begin
            case (apb.paddr)
                `VEND_ADDR_PRICE:   apb_rsp.prdata = 32'(price_q);
                `VEND_ADDR_SALES:   apb_rsp.prdata = 32'(sales_q);
                `VEND_ADDR_REJECTS: apb_rsp.prdata = 32'(rejects_q);
                `VEND_ADDR_STATUS:  apb_rsp.prdata = {23'd0, busy, 1'b0, credit};
                default:            apb_rsp.prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/vending_top.sv */
`timescale 1ns/100ps
`default_nettype none

module vending_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire vend_pkg::coin_t  coin_pins,
    input  wire                 coin_return,
    input  wire vend_pkg::apb_req_t apb,
    output vend_pkg::apb_rsp_t  apb_rsp,
    output logic                dispense,
    output vend_pkg::amount_t   credit,
    output vend_pkg::coin_t     coin_out,
    output logic                busy
);

    vend_pkg::coin_t   coin_evt;
    logic              coin_valid;
    logic              reject;
    logic              accept_en;
    vend_pkg::amount_t price;
    logic              pay_start;
    vend_pkg::amount_t pay_amount;
    logic              pay_busy;

    coin_acceptor u_acceptor (
        .clk        (clk),
        .rst_n      (rst_n),
        .coin_pins  (coin_pins),
        .accept_en  (accept_en),
        .coin_evt   (coin_evt),
        .coin_valid (coin_valid),
        .reject     (reject)
    );

    vend_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .coin_evt    (coin_evt),
        .coin_valid  (coin_valid),
        .coin_return (coin_return),
        .price       (price),
        .accept_en   (accept_en),
        .dispense    (dispense),
        .credit      (credit),
        .pay_start   (pay_start),
        .pay_amount  (pay_amount),
        .pay_busy    (pay_busy),
        .busy        (busy)
    );

    change_maker u_change (
        .clk        (clk),
        .rst_n      (rst_n),
        .pay_start  (pay_start),
        .pay_amount (pay_amount),
        .pay_busy   (pay_busy),
        .coin_out   (coin_out)
    );

    vend_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb      (apb),
        .apb_rsp  (apb_rsp),
        .price    (price),
        .dispense (dispense),
        .reject   (reject),
        .credit   (credit),
        .busy     (busy)
    );

endmodule

`default_nettype wire

/* tests/tb_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* tests/vending_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module vending_sva (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  dispense,
    input wire                  busy,
    input wire vend_pkg::coin_t coin_out
);

    int fail_cnt = 0;                           // Failed assertions so far.

    a_coin_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(coin_out))
        else begin
            fail_cnt++;
            $error("coin_out ejects more than one coin at once");
        end

    a_dispense_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        dispense |=> !dispense)
        else begin
            fail_cnt++;
            $error("dispense held longer than one cycle");
        end

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> (coin_out == '0 && !dispense))
        else begin
            fail_cnt++;
            $error("coin_out or dispense active while not busy");
        end

endmodule

`default_nettype wire

/* tests/vending_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vend_consts.svh"

module vending_tb;

    typedef struct packed {
        logic [3:0] quarters;
        logic [3:0] dimes;
        logic [3:0] nickels;
    } coin_cnt_t;

    logic               clk;
    logic               rst_n;
    vend_pkg::coin_t    coin_pins;
    logic               coin_return;
    vend_pkg::apb_req_t apb;
    vend_pkg::apb_rsp_t apb_rsp;
    logic               dispense;
    vend_pkg::amount_t  credit;
    vend_pkg::coin_t    coin_out;
    logic               busy;

    integer            seed = 32'hdf99_23fd;
    integer            errors = 0;
    integer            timeouts = 0;
    integer            txn_sent = 0;
    integer            txn_done = 0;
    integer            sales_exp = 0;
    integer            disp_cnt = 0;
    logic              exp_disp = 1'b0;
    vend_pkg::amount_t exp_total = '0;
    vend_pkg::amount_t exp_pay = '0;
    vend_pkg::amount_t model_price;             // Price the next sale is judged by.
    coin_cnt_t         got = '0;
    logic              busy_d = 1'b0;
    logic [31:0]       rdata;
    vend_pkg::coin_t   c;

    tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    vending_top UUT (
        .clk(clk), .rst_n(rst_n), .coin_pins(coin_pins), .coin_return(coin_return),
        .apb(apb), .apb_rsp(apb_rsp), .dispense(dispense), .credit(credit),
        .coin_out(coin_out), .busy(busy)
    );

    bind vending_top vending_sva u_sva (
        .clk(clk), .rst_n(rst_n), .dispense(dispense), .busy(busy), .coin_out(coin_out)
    );

    // Greedy change, largest coin first.
    function automatic coin_cnt_t change_of(vend_pkg::amount_t amt);
        coin_cnt_t cnt;
        int        rest;
        rest         = amt;
        cnt.quarters = 4'(rest / `VEND_COIN_QUARTER);
        rest         = rest % `VEND_COIN_QUARTER;
        cnt.dimes    = 4'(rest / `VEND_COIN_DIME);
        rest         = rest % `VEND_COIN_DIME;
        cnt.nickels  = 4'(rest / `VEND_COIN_NICKEL);
        return cnt;
    endfunction

    function automatic vend_pkg::amount_t coin_value(vend_pkg::coin_t coin);
        if (coin.quarter)
            return vend_pkg::amount_t'(`VEND_COIN_QUARTER);
        if (coin.dime)
            return vend_pkg::amount_t'(`VEND_COIN_DIME);
        return vend_pkg::amount_t'(`VEND_COIN_NICKEL);
    endfunction

    function automatic vend_pkg::coin_t random_coin();
        vend_pkg::coin_t coin;
        int              r;
        coin = '0;
        r    = {$random(seed)} % 3;
        if (r == 0)
            coin.nickel = 1'b1;
        else if (r == 1)
            coin.dime = 1'b1;
        else
            coin.quarter = 1'b1;
        return coin;
    endfunction

    // **********************************************************************
    // Compare tasks and run control
    // **********************************************************************
    task automatic check_amount(vend_pkg::amount_t act, vend_pkg::amount_t exp, string what);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_count(vend_pkg::count_t act, vend_pkg::count_t exp, string what);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_flag(logic act, logic exp, string what);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_coins(coin_cnt_t act, coin_cnt_t exp, string what);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s are q%0d d%0d n%0d, expected q%0d d%0d n%0d",
                     $time, what, act.quarters, act.dimes, act.nickels,
                     exp.quarters, exp.dimes, exp.nickels);
        end
    endtask

    task automatic end_run();
        $display("Mismatches: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, UUT.u_sva.fail_cnt, timeouts);
        if (errors == 0 && timeouts == 0 && UUT.u_sva.fail_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    endtask

    task automatic give_up(string what);
        timeouts++;
        $display("Timed out at %0t while waiting for %s", $time, what);
        end_run();
    endtask

    task automatic wait_reset();
        int cnt;
        cnt = 0;
        while (!rst_n && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        if (!rst_n)
            give_up("reset release");
    endtask

    task automatic wait_credit(vend_pkg::amount_t amt);
        int cnt;
        cnt = 0;
        while (credit !== amt && cnt < 20) begin
            @(negedge clk);
            cnt++;
        end
        if (credit !== amt)
            give_up("the credit to reach the inserted sum");
    endtask

    task automatic wait_done(int n);
        int cnt;
        cnt = 0;
        while (txn_done < n && cnt < 100) begin
            @(negedge clk);
            cnt++;
        end
        if (txn_done < n)
            give_up("the end of a transaction");
    endtask

    // **********************************************************************
    // Stimulus tasks
    // **********************************************************************
    task automatic apb_access(logic write, logic [7:0] addr, logic [31:0] data,
                              output logic [31:0] rd, output logic slverr);
        int cnt;
        @(posedge clk);
        apb <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        cnt = 0;
        while (!apb_rsp.pready && cnt < 16) begin
            @(negedge clk);
            cnt++;
        end
        if (!apb_rsp.pready)
            give_up("APB pready");
        rd     = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic write_reg(logic [7:0] addr, logic [31:0] data, logic exp_err);
        logic [31:0] rd;
        logic        slverr;
        apb_access(1'b1, addr, data, rd, slverr);
        check_flag(slverr, exp_err, "pslverr on write");
    endtask

    task automatic read_reg(logic [7:0] addr, output logic [31:0] rd);
        logic slverr;
        apb_access(1'b0, addr, '0, rd, slverr);
        check_flag(slverr, 1'b0, "pslverr on read");
    endtask

    task automatic insert_coin(vend_pkg::coin_t coin);
        int gap;
        gap = 4 + {$random(seed)} % 5;
        @(posedge clk);
        coin_pins <= coin;
        repeat (2) @(posedge clk);              // Two-cycle pulse.
        coin_pins <= '0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic purchase(logic exact);
        vend_pkg::coin_t   coin;
        vend_pkg::amount_t sum;
        sum = '0;
        txn_sent++;
        while (sum < model_price) begin
            coin = random_coin();
            if (exact) begin
                coin      = '0;
                coin.dime = (model_price - sum >= `VEND_COIN_DIME);
                coin.nickel = !coin.dime;
            end
            if (sum + coin_value(coin) >= model_price) begin
                exp_disp  = 1'b1;
                exp_total = sum + coin_value(coin);
                exp_pay   = exp_total - model_price;
            end
            sum = sum + coin_value(coin);
            insert_coin(coin);
        end
        sales_exp++;
        wait_done(txn_sent);
    endtask

    task automatic refund(int n);
        vend_pkg::coin_t   coin;
        vend_pkg::amount_t sum;
        coin        = '0;
        coin.nickel = 1'b1;
        sum         = coin_value(coin);
        insert_coin(coin);
        repeat (n) begin
            coin = random_coin();
            if (sum + coin_value(coin) < model_price) begin
                sum = sum + coin_value(coin);
                insert_coin(coin);
            end
        end
        wait_credit(sum);
        read_reg(`VEND_ADDR_STATUS, rdata);
        check_count(vend_pkg::count_t'(rdata), 16'h0100 | vend_pkg::count_t'(sum),
                    "STATUS while collecting");   // Busy in bit 8.
        exp_disp  = 1'b0;
        exp_total = sum;
        exp_pay   = sum;
        txn_sent++;
        @(posedge clk);
        coin_return <= 1'b1;
        @(posedge clk);
        coin_return <= 1'b0;
        wait_done(txn_sent);
    endtask

    // Counts what leaves the machine during one busy window.
    always @(negedge clk) begin
        if (rst_n) begin
            if (busy && !busy_d) begin
                got      = '0;
                disp_cnt = 0;
            end
            if (busy) begin
                got.quarters = got.quarters + 4'(coin_out.quarter);
                got.dimes    = got.dimes + 4'(coin_out.dime);
                got.nickels  = got.nickels + 4'(coin_out.nickel);
                if (dispense) begin
                    disp_cnt++;
                    check_amount(credit, exp_total, "credit at dispense");
                end
            end else if (busy_d) begin
                check_count(vend_pkg::count_t'(disp_cnt), vend_pkg::count_t'(exp_disp),
                            "dispense pulses");
                check_coins(got, change_of(exp_pay), "ejected coins");
                check_amount(credit, '0, "credit after transaction");
                txn_done++;
            end
            busy_d = busy;
        end
    end

    // **********************************************************************
    // Test sequence
    // **********************************************************************
    initial begin
        coin_pins   = '0;
        coin_return = 1'b0;
        apb         = '0;
        model_price = vend_pkg::amount_t'(`VEND_PRICE_DEFAULT);
        wait_reset();
        @(negedge clk);
        check_flag(dispense, 1'b0, "dispense after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(|coin_out, 1'b0, "coin_out after reset");
        check_flag(apb_rsp.pslverr, 1'b0, "pslverr after reset");
        check_amount(credit, '0, "credit after reset");
        read_reg(`VEND_ADDR_PRICE, rdata);
        check_amount(vend_pkg::amount_t'(rdata), model_price, "PRICE");
        read_reg(`VEND_ADDR_SALES, rdata);
        check_count(vend_pkg::count_t'(rdata), '0, "SALES");
        read_reg(`VEND_ADDR_REJECTS, rdata);
        check_count(vend_pkg::count_t'(rdata), '0, "REJECTS");
        read_reg(`VEND_ADDR_STATUS, rdata);
        check_count(vend_pkg::count_t'(rdata), '0, "STATUS");

        purchase(1'b1);                         // Exact change.
        read_reg(`VEND_ADDR_SALES, rdata);
        check_count(vend_pkg::count_t'(rdata), vend_pkg::count_t'(sales_exp), "SALES");
        repeat (6) purchase(1'b0);
        repeat (3) refund(3);

        write_reg(`VEND_ADDR_PRICE, 32'd45, 1'b0);
        model_price = vend_pkg::amount_t'(45);
        repeat (4) purchase(1'b0);
        write_reg(`VEND_ADDR_PRICE, 32'd33, 1'b1);
        write_reg(`VEND_ADDR_PRICE, 32'd100, 1'b1);
        write_reg(`VEND_ADDR_PRICE, 32'd0, 1'b1);
        write_reg(`VEND_ADDR_SALES, 32'd7, 1'b1);
        read_reg(`VEND_ADDR_PRICE, rdata);
        check_amount(vend_pkg::amount_t'(rdata), model_price, "PRICE after bad writes");

        // Quarter completes the sale and the nickel behind it hits VEND.
        write_reg(`VEND_ADDR_PRICE, 32'd30, 1'b0);
        model_price = vend_pkg::amount_t'(30);
        txn_sent++;
        exp_disp  = 1'b1;
        exp_total = model_price;
        exp_pay   = '0;
        c         = '0;
        c.nickel  = 1'b1;
        insert_coin(c);
        c.quarter = 1'b1;
        insert_coin(c);
        sales_exp++;
        wait_done(txn_sent);
        read_reg(`VEND_ADDR_REJECTS, rdata);
        check_count(vend_pkg::count_t'(rdata), 16'd1, "REJECTS");
        write_reg(`VEND_ADDR_REJECTS, 32'd0, 1'b0);
        read_reg(`VEND_ADDR_REJECTS, rdata);
        check_count(vend_pkg::count_t'(rdata), '0, "REJECTS after clear");
        read_reg(`VEND_ADDR_SALES, rdata);
        check_count(vend_pkg::count_t'(rdata), vend_pkg::count_t'(sales_exp), "SALES");
        end_run();
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/vend_pkg.sv
hdl/coin_acceptor.sv
hdl/vend_fsm.sv
hdl/change_maker.sv
hdl/vend_regs.sv
hdl/vending_top.sv
tests/tb_clkgen.sv
tests/vending_sva.sv
tests/vending_tb.sv
